// File: hw/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define ID_XLEN         32
`define ID_REG_CNT      32
`define ID_RADDR_W      5
`define ID_ALU_OP_W     12
`define ID_LINK_REG     5'd1          // bl writes its return address here

// op_31_26 group codes
`define ID_OP_ALU_31_26 6'h00
`define ID_OP_MEM_31_26 6'h0a
`define ID_OP_LU12I_W   6'h05         // also needs inst[25] == 0
`define ID_OP_JIRL      6'h13
`define ID_OP_B         6'h14
`define ID_OP_BL        6'h15
`define ID_OP_BEQ       6'h16
`define ID_OP_BNE       6'h17
`define ID_OP_BLT       6'h18
`define ID_OP_BGE       6'h19
`define ID_OP_BLTU      6'h1a
`define ID_OP_BGEU      6'h1b

// op_25_22 codes
`define ID_OP_RR_25_22  4'h0
`define ID_OP_ADDI_W    4'ha
`define ID_OP_LD_W      4'h2
`define ID_OP_ST_W      4'h6

// three-register group, op_21_20 then op_19_15
`define ID_OP_RR_21_20  2'h1
`define ID_OP_ADD_W     5'h00
`define ID_OP_SUB_W     5'h02
`define ID_OP_SLT       5'h04
`define ID_OP_SLTU      5'h05
`define ID_OP_NOR       5'h08
`define ID_OP_AND       5'h09
`define ID_OP_OR        5'h0a
`define ID_OP_XOR       5'h0b

`endif

// File: hw/id_pkg.sv
`default_nettype none
`include "id_macros.svh"

package id_pkg;

    // bit position inside alu_op with 8..10 reserved
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_lui  = 4'd11
    } alu_op_e;

    typedef logic [`ID_ALU_OP_W-1:0] alu_op_t;

    typedef enum logic [3:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu,
        br_jump,    // b and bl
        br_jirl
    } br_kind_e;

    typedef struct packed {
        logic [`ID_XLEN-1:0] inst;
        logic [`ID_XLEN-1:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        logic                taken;
        logic [`ID_XLEN-1:0] target;
    } br_bus_t;

    // mem/wb forwarding and the register file write port
    typedef struct packed {
        logic                   we;
        logic [`ID_RADDR_W-1:0] waddr;
        logic [`ID_XLEN-1:0]    wdata;
    } wr_bus_t;

    typedef struct packed {
        logic                   res_from_mem;   // ex holds a load whose wdata is not ready yet
        logic                   we;
        logic [`ID_RADDR_W-1:0] waddr;
        logic [`ID_XLEN-1:0]    wdata;
    } ex_fwd_bus_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic [`ID_XLEN-1:0]    imm;        // branch offset for jumps
        logic                   res_from_mem;
        logic                   mem_we;
        logic                   rf_we;
        logic [`ID_RADDR_W-1:0] rf_waddr;
        logic [`ID_RADDR_W-1:0] rs1;
        logic [`ID_RADDR_W-1:0] rs2;
        logic                   need_r1;
        logic                   need_r2;
        br_kind_e               br_kind;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic                   res_from_mem;
        logic [`ID_XLEN-1:0]    src1;
        logic [`ID_XLEN-1:0]    src2;
        logic                   mem_we;
        logic                   rf_we;
        logic [`ID_RADDR_W-1:0] rf_waddr;
        logic [`ID_XLEN-1:0]    rkd_value;  // store data
        logic [`ID_XLEN-1:0]    pc;
    } ex_bus_t;

endpackage

`default_nettype wire

// File: hw/id_latch.sv
`default_nettype none
`include "id_macros.svh"

module id_latch import id_pkg::*; (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  in_valid,
    input  wire fetch_bus_t      in_bus,
    input  wire                  ready_go,
    input  wire                  out_allowin,
    input  wire                  br_taken,
    output logic                 allowin,
    output logic                 valid,
    output logic [`ID_XLEN-1:0]  inst,
    output logic [`ID_XLEN-1:0]  pc,
    output logic                 ex_valid
);

    assign allowin  = ~valid | (ready_go & out_allowin);
    assign ex_valid = valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (br_taken) begin
            valid <= 1'b0;          // wrong-path fetch is dropped
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    // payload held while the stage waits
    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            inst <= in_bus.inst;
            pc   <= in_bus.pc;
        end
    end

    squash_clears_valid: assert property (
        @(posedge clk) disable iff (!resetn)
        br_taken |=> $past(valid) && !valid
    ) else $error("id_latch: squash from an empty stage or valid kept after it");

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none
`include "id_macros.svh"

module inst_decoder import id_pkg::*; (
    input  wire [`ID_XLEN-1:0] inst,
    input  wire                valid,
    output dec_ctrl_t          ctrl
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        rr_grp;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_and, inst_or, inst_nor, inst_xor;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic        inst_b, inst_bl, inst_jirl;
    logic        inst_rr;
    logic        cond_br;
    logic        src_reg_is_rd;
    alu_op_t     alu_op;
    br_kind_e    br_kind;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i16      = inst[25:10];
    assign i20      = inst[24:5];
    assign i26      = {inst[9:0], inst[25:10]};   // offs[25:16] sits in the low bits

    assign rr_grp = (op_31_26 == `ID_OP_ALU_31_26) && (op_25_22 == `ID_OP_RR_25_22)
                 && (op_21_20 == `ID_OP_RR_21_20);

    assign inst_add_w   = rr_grp && (op_19_15 == `ID_OP_ADD_W);
    assign inst_sub_w   = rr_grp && (op_19_15 == `ID_OP_SUB_W);
    assign inst_slt     = rr_grp && (op_19_15 == `ID_OP_SLT);
    assign inst_sltu    = rr_grp && (op_19_15 == `ID_OP_SLTU);
    assign inst_nor     = rr_grp && (op_19_15 == `ID_OP_NOR);
    assign inst_and     = rr_grp && (op_19_15 == `ID_OP_AND);
    assign inst_or      = rr_grp && (op_19_15 == `ID_OP_OR);
    assign inst_xor     = rr_grp && (op_19_15 == `ID_OP_XOR);
    assign inst_addi_w  = (op_31_26 == `ID_OP_ALU_31_26) && (op_25_22 == `ID_OP_ADDI_W);
    assign inst_ld_w    = (op_31_26 == `ID_OP_MEM_31_26) && (op_25_22 == `ID_OP_LD_W);
    assign inst_st_w    = (op_31_26 == `ID_OP_MEM_31_26) && (op_25_22 == `ID_OP_ST_W);
    assign inst_lu12i_w = (op_31_26 == `ID_OP_LU12I_W) && !inst[25];
    assign inst_jirl    = (op_31_26 == `ID_OP_JIRL);
    assign inst_b       = (op_31_26 == `ID_OP_B);
    assign inst_bl      = (op_31_26 == `ID_OP_BL);
    assign inst_beq     = (op_31_26 == `ID_OP_BEQ);
    assign inst_bne     = (op_31_26 == `ID_OP_BNE);
    assign inst_blt     = (op_31_26 == `ID_OP_BLT);
    assign inst_bge     = (op_31_26 == `ID_OP_BGE);
    assign inst_bltu    = (op_31_26 == `ID_OP_BLTU);
    assign inst_bgeu    = (op_31_26 == `ID_OP_BGEU);

    assign inst_rr = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                   | inst_and | inst_or | inst_nor | inst_xor;
    assign cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign src_reg_is_rd = cond_br | inst_st_w;   // rd is read, not written

    always_comb begin
        alu_op            = '0;
        alu_op[alu_add]   = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                          | inst_jirl | inst_bl;    // address calc and link value
        alu_op[alu_sub]   = inst_sub_w;
        alu_op[alu_slt]   = inst_slt;
        alu_op[alu_sltu]  = inst_sltu;
        alu_op[alu_and]   = inst_and;
        alu_op[alu_nor]   = inst_nor;
        alu_op[alu_or]    = inst_or;
        alu_op[alu_xor]   = inst_xor;
        alu_op[alu_lui]   = inst_lu12i_w;
    end

    always_comb begin
        if (!valid)         br_kind = br_none;
        else if (inst_beq)  br_kind = br_eq;
        else if (inst_bne)  br_kind = br_ne;
        else if (inst_blt)  br_kind = br_lt;
        else if (inst_bge)  br_kind = br_ge;
        else if (inst_bltu) br_kind = br_ltu;
        else if (inst_bgeu) br_kind = br_geu;
        else if (inst_b || inst_bl) br_kind = br_jump;
        else if (inst_jirl) br_kind = br_jirl;
        else                br_kind = br_none;
    end

    assign ctrl.alu_op      = alu_op;
    assign ctrl.src1_is_pc  = inst_bl | inst_jirl;   // link value is pc plus 4
    assign ctrl.src2_is_imm = inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w;
    assign ctrl.imm = inst_lu12i_w         ? {i20, 12'b0} :
                      (inst_b | inst_bl)   ? {{4{i26[25]}}, i26, 2'b0} :
                      (cond_br | inst_jirl) ? {{14{i16[15]}}, i16, 2'b0} :
                      {{20{i12[11]}}, i12};

    assign ctrl.res_from_mem = valid & inst_ld_w;
    assign ctrl.mem_we       = valid & inst_st_w;
    assign ctrl.rf_we        = valid & (inst_rr | inst_addi_w | inst_lu12i_w | inst_ld_w
                                      | inst_bl | inst_jirl);
    assign ctrl.rf_waddr     = inst_bl ? `ID_LINK_REG : rd;
    assign ctrl.rs1          = rj;
    assign ctrl.rs2          = src_reg_is_rd ? rd : rk;
    assign ctrl.need_r1      = valid & (inst_rr | inst_addi_w | inst_ld_w | inst_st_w
                                      | cond_br | inst_jirl);
    assign ctrl.need_r2      = valid & (inst_rr | cond_br | inst_st_w);
    assign ctrl.br_kind      = br_kind;

endmodule

`default_nettype wire

// File: hw/regfile.sv
`default_nettype none
`include "id_macros.svh"

module regfile import id_pkg::*; (
    input  wire                    clk,
    input  wire [`ID_RADDR_W-1:0]  raddr1,
    input  wire [`ID_RADDR_W-1:0]  raddr2,
    output logic [`ID_XLEN-1:0]    rdata1,
    output logic [`ID_XLEN-1:0]    rdata2,
    input  wire wr_bus_t           wr
);

    logic [`ID_XLEN-1:0] rf [`ID_REG_CNT];

    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            rf[wr.waddr] <= wr.wdata;   // r0 stays zero
        end
    end

    // same-cycle wb data arrives through forwarding, not here
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

// File: hw/operand_unit.sv
`default_nettype none
`include "id_macros.svh"

module operand_unit import id_pkg::*; (
    input  wire                  clk,
    input  wire dec_ctrl_t       ctrl,
    input  wire ex_fwd_bus_t     ex_fwd,
    input  wire wr_bus_t         mem_fwd,
    input  wire wr_bus_t         wb_fwd,
    output logic [`ID_XLEN-1:0]  rj_value,
    output logic [`ID_XLEN-1:0]  rkd_value,
    output logic                 stall
);

    logic [`ID_XLEN-1:0] rf_rdata1;
    logic [`ID_XLEN-1:0] rf_rdata2;
    logic                r1_ex;
    logic                r1_mem;
    logic                r1_wb;
    logic                r2_ex;
    logic                r2_mem;
    logic                r2_wb;

    // needed, nonzero and written by that stage
    function automatic logic src_hit(
        input logic                   need,
        input logic [`ID_RADDR_W-1:0] src,
        input logic                   we,
        input logic [`ID_RADDR_W-1:0] waddr
    );
        return need && (src != '0) && we && (src == waddr);
    endfunction

    function automatic logic [`ID_XLEN-1:0] fwd_sel(
        input logic                hit_ex,
        input logic                hit_mem,
        input logic                hit_wb,
        input logic [`ID_XLEN-1:0] rf_val
    );
        logic [`ID_XLEN-1:0] val;
        if (hit_ex)       val = ex_fwd.wdata;   // youngest result wins
        else if (hit_mem) val = mem_fwd.wdata;
        else if (hit_wb)  val = wb_fwd.wdata;
        else              val = rf_val;
        return val;
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_fwd)
    );

    assign r1_ex  = src_hit(ctrl.need_r1, ctrl.rs1, ex_fwd.we, ex_fwd.waddr);
    assign r1_mem = src_hit(ctrl.need_r1, ctrl.rs1, mem_fwd.we, mem_fwd.waddr);
    assign r1_wb  = src_hit(ctrl.need_r1, ctrl.rs1, wb_fwd.we, wb_fwd.waddr);
    assign r2_ex  = src_hit(ctrl.need_r2, ctrl.rs2, ex_fwd.we, ex_fwd.waddr);
    assign r2_mem = src_hit(ctrl.need_r2, ctrl.rs2, mem_fwd.we, mem_fwd.waddr);
    assign r2_wb  = src_hit(ctrl.need_r2, ctrl.rs2, wb_fwd.we, wb_fwd.waddr);

    assign rj_value  = fwd_sel(r1_ex, r1_mem, r1_wb, rf_rdata1);
    assign rkd_value = fwd_sel(r2_ex, r2_mem, r2_wb, rf_rdata2);

    // a load in ex has its data only after mem
    assign stall = ex_fwd.res_from_mem & (r1_ex | r2_ex);

    load_writes_reg: assert property (
        @(posedge clk) ex_fwd.res_from_mem |-> ex_fwd.we
    ) else $error("operand_unit: load in ex without a register write");

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`default_nettype none
`include "id_macros.svh"

module branch_unit import id_pkg::*; (
    input  wire dec_ctrl_t        ctrl,
    input  wire [`ID_XLEN-1:0]    pc,
    input  wire [`ID_XLEN-1:0]    rj_value,
    input  wire [`ID_XLEN-1:0]    rkd_value,
    output br_bus_t               br
);

    logic rj_eq_rd;
    logic rj_lt_rd;
    logic rj_ltu_rd;
    logic cond;

    assign rj_eq_rd  = (rj_value == rkd_value);
    assign rj_lt_rd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rd = (rj_value < rkd_value);

    // br_none also covers an empty stage
    always_comb begin
        case (ctrl.br_kind)
            br_eq:   cond = rj_eq_rd;
            br_ne:   cond = !rj_eq_rd;
            br_lt:   cond = rj_lt_rd;
            br_ge:   cond = !rj_lt_rd;
            br_ltu:  cond = rj_ltu_rd;
            br_geu:  cond = !rj_ltu_rd;
            br_jump: cond = 1'b1;
            br_jirl: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign br.taken  = cond;
    // imm already holds the shifted offset
    assign br.target = (ctrl.br_kind == br_jirl) ? (rj_value + ctrl.imm)
                                                 : (pc + ctrl.imm);

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`default_nettype none
`include "id_macros.svh"

module id_stage import id_pkg::*; (
    input  wire              clk,
    input  wire              resetn,
    input  wire              if_valid,
    input  wire fetch_bus_t  if_bus,
    output logic             allowin,
    output br_bus_t          br_bus,
    input  wire              ex_allowin,
    output logic             ex_valid,
    output ex_bus_t          ex_bus,
    input  wire ex_fwd_bus_t ex_fwd,
    input  wire wr_bus_t     mem_fwd,
    input  wire wr_bus_t     wb_fwd
);

    logic                valid;
    logic [`ID_XLEN-1:0] inst;
    logic [`ID_XLEN-1:0] pc;
    logic                stall;
    logic                ready_go;
    logic                br_fire;
    logic [`ID_XLEN-1:0] rj_value;
    logic [`ID_XLEN-1:0] rkd_value;
    dec_ctrl_t           ctrl;
    br_bus_t             br;

    assign ready_go = ~stall;
    // redirect only once the branch actually moves on to ex
    assign br_fire  = br.taken & ready_go & ex_allowin;

    id_latch u_latch (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (if_valid),
        .in_bus      (if_bus),
        .ready_go    (ready_go),
        .out_allowin (ex_allowin),
        .br_taken    (br_fire),
        .allowin     (allowin),
        .valid       (valid),
        .inst        (inst),
        .pc          (pc),
        .ex_valid    (ex_valid)
    );

    inst_decoder u_dec (.inst(inst), .valid(valid), .ctrl(ctrl));

    operand_unit u_opnd (
        .clk       (clk),
        .ctrl      (ctrl),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit u_br (.ctrl(ctrl), .pc(pc), .rj_value(rj_value), .rkd_value(rkd_value), .br(br));

    assign br_bus.taken  = br_fire;
    assign br_bus.target = br.target;

    assign ex_bus.alu_op       = ctrl.alu_op;
    assign ex_bus.res_from_mem = ctrl.res_from_mem;
    assign ex_bus.src1         = ctrl.src1_is_pc ? pc : rj_value;
    assign ex_bus.src2         = ctrl.src1_is_pc  ? `ID_XLEN'd4 :   // return address pc + 4
                                 ctrl.src2_is_imm ? ctrl.imm : rkd_value;
    assign ex_bus.mem_we       = ctrl.mem_we;
    assign ex_bus.rf_we        = ctrl.rf_we;
    assign ex_bus.rf_waddr     = ctrl.rf_waddr;
    assign ex_bus.rkd_value    = rkd_value;
    assign ex_bus.pc           = pc;

endmodule

`default_nettype wire

// File: sim/tb_id_stage.sv
`default_nettype none
`include "id_macros.svh"

module tb_id_stage import id_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        resetn;
    logic        if_valid;
    fetch_bus_t  if_bus;
    logic        allowin;
    br_bus_t     br_bus;
    logic        ex_allowin;
    logic        ex_valid;
    ex_bus_t     ex_bus;
    ex_fwd_bus_t ex_fwd;
    wr_bus_t     mem_fwd;
    wr_bus_t     wb_fwd;

    logic [31:0] seed = 32'h59c9;
    logic [31:0] regs [32];     // model of the register file
    int          errors = 0;
    int          timeouts = 0;

    id_stage u_dut (
        .clk        (clk),
        .resetn     (resetn),
        .if_valid   (if_valid),
        .if_bus     (if_bus),
        .allowin    (allowin),
        .br_bus     (br_bus),
        .ex_allowin (ex_allowin),
        .ex_valid   (ex_valid),
        .ex_bus     (ex_bus),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [31:0] enc_rr(input logic [4:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {`ID_OP_ALU_31_26, `ID_OP_RR_25_22, `ID_OP_RR_21_20, op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [5:0] op6, input logic [3:0] op4,
                                            input logic [11:0] si, input logic [4:0] rj,
                                            input logic [4:0] rd);
        return {op6, op4, si, rj, rd};
    endfunction

    function automatic ex_bus_t expect_bus(input alu_op_e op, input logic [31:0] s1,
                                           input logic [31:0] s2, input logic rf_we,
                                           input logic [4:0] waddr, input logic [31:0] rkd,
                                           input logic [31:0] pc, input logic mem_we,
                                           input logic is_load);
        ex_bus_t e;
        e              = '0;
        e.alu_op[op]   = 1'b1;
        e.res_from_mem = is_load;
        e.src1         = s1;
        e.src2         = s2;
        e.mem_we       = mem_we;
        e.rf_we        = rf_we;
        e.rf_waddr     = waddr;
        e.rkd_value    = rkd;
        e.pc           = pc;
        return e;
    endfunction

    // src1 or rkd_value can be don't care for some instructions
    task automatic check_ex_bus(input string name, input ex_bus_t exp,
                                input bit chk_src1, input bit chk_rkd);
        if (!chk_src1) exp.src1 = ex_bus.src1;
        if (!chk_rkd) exp.rkd_value = ex_bus.rkd_value;
        if (ex_bus !== exp) begin
            errors++;
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, ex_bus);
        end
    endtask

    task automatic check_br(input string name, input br_bus_t exp);
        if (br_bus !== exp) begin
            errors++;
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, br_bus);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, exp, act);
        end
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        @(negedge clk);
        while (!allowin && n < 20) begin
            n++;
            @(negedge clk);
        end
        if (!allowin) begin
            timeouts++;
            $display("timeout at %0t: the stage never accepted an instruction", $time);
        end
    endtask

    task automatic wait_ex_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!ex_valid && n < 20) begin
            n++;
            @(negedge clk);
        end
        if (!ex_valid) begin
            timeouts++;
            $display("timeout at %0t: ex_valid never went high", $time);
        end
    endtask

    // returns right after the capture edge
    task automatic issue(input logic [31:0] inst, input logic [31:0] pc);
        @(posedge clk);
        if_valid <= 1'b1;
        if_bus   <= '{inst, pc};
        wait_allowin();
        @(posedge clk);
        if_valid <= 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        ex_allowin <= 1'b1;
        if_valid   <= 1'b0;
        ex_fwd     <= '0;
        mem_fwd    <= '0;
        wb_fwd     <= '0;
        @(posedge clk);
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] val);
        @(posedge clk);
        wb_fwd <= '{1'b1, addr, val};
        @(posedge clk);
        wb_fwd <= '0;
        if (addr != 5'd0) regs[addr] = val;
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_bit("ex_valid", 1'b0, ex_valid);
        check_bit("br_bus.taken", 1'b0, br_bus.taken);
        check_bit("ex_bus.rf_we", 1'b0, ex_bus.rf_we);
        check_bit("ex_bus.mem_we", 1'b0, ex_bus.mem_we);
    endtask

    task automatic alu_decode();
        logic [4:0]  rr_codes [8] = '{`ID_OP_ADD_W, `ID_OP_SUB_W, `ID_OP_SLT, `ID_OP_SLTU,
                                      `ID_OP_AND, `ID_OP_OR, `ID_OP_NOR, `ID_OP_XOR};
        alu_op_e     rr_ops [8] = '{alu_add, alu_sub, alu_slt, alu_sltu,
                                    alu_and, alu_or, alu_nor, alu_xor};
        logic [31:0] pc;
        logic [31:0] r;
        logic [31:0] sext;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        for (int i = 1; i < 32; i++) begin
            write_reg(5'(i), lcg_next());
        end
        for (int i = 0; i < 8; i++) begin
            rd = 5'(20 + i);
            rj = 5'(1 + i);
            rk = 5'(9 + i);
            pc = 32'h1c00_0000 + 32'(i * 4);
            issue(enc_rr(rr_codes[i], rd, rj, rk), pc);
            @(negedge clk);
            check_bit("ex_valid", 1'b1, ex_valid);
            check_ex_bus("ex_bus rr", expect_bus(rr_ops[i], regs[rj], regs[rk], 1'b1, rd,
                         regs[rk], pc, 1'b0, 1'b0), 1'b1, 1'b1);
        end
        r = lcg_next();
        sext = {{20{r[11]}}, r[11:0]};
        issue(enc_i12(`ID_OP_ALU_31_26, `ID_OP_ADDI_W, r[11:0], 5'd3, 5'd4), pc);
        @(negedge clk);
        check_ex_bus("ex_bus addi.w", expect_bus(alu_add, regs[3], sext, 1'b1, 5'd4, '0, pc,
                     1'b0, 1'b0), 1'b1, 1'b0);
        issue({`ID_OP_LU12I_W, 1'b0, r[31:12], 5'd5}, pc);
        @(negedge clk);
        check_ex_bus("ex_bus lu12i.w", expect_bus(alu_lui, '0, {r[31:12], 12'b0}, 1'b1, 5'd5,
                     '0, pc, 1'b0, 1'b0), 1'b0, 1'b0);
        issue(enc_i12(`ID_OP_MEM_31_26, `ID_OP_LD_W, r[11:0], 5'd7, 5'd6), pc);
        @(negedge clk);
        check_ex_bus("ex_bus ld.w", expect_bus(alu_add, regs[7], sext, 1'b1, 5'd6, '0, pc,
                     1'b0, 1'b1), 1'b1, 1'b0);
        issue(enc_i12(`ID_OP_MEM_31_26, `ID_OP_ST_W, r[11:0], 5'd9, 5'd8), pc);
        @(negedge clk);
        check_ex_bus("ex_bus st.w", expect_bus(alu_add, regs[9], sext, 1'b0, 5'd8, regs[8],
                     pc, 1'b1, 1'b0), 1'b1, 1'b1);
        issue({`ID_OP_BL, r[15:0], r[25:16]}, pc);
        @(negedge clk);
        check_ex_bus("ex_bus bl", expect_bus(alu_add, pc, 32'd4, 1'b1, `ID_LINK_REG, '0, pc,
                     1'b0, 1'b0), 1'b1, 1'b0);
        drain();
    endtask

    task automatic forward_priority();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] pc;
        a  = lcg_next();
        b  = lcg_next();
        c  = lcg_next();
        d  = lcg_next();
        pc = 32'h1c00_1000;
        @(posedge clk);
        ex_allowin <= 1'b0;         // hold the add in the stage
        ex_fwd     <= '{1'b0, 1'b1, 5'd5, a};
        mem_fwd    <= '{1'b1, 5'd5, b};
        wb_fwd     <= '{1'b1, 5'd5, c};
        issue(enc_rr(`ID_OP_ADD_W, 5'd3, 5'd5, 5'd6), pc);
        @(negedge clk);
        check_ex_bus("ex_bus fwd ex", expect_bus(alu_add, a, regs[6], 1'b1, 5'd3, regs[6], pc,
                     1'b0, 1'b0), 1'b1, 1'b1);
        @(posedge clk);
        ex_fwd <= '0;
        @(negedge clk);
        check_ex_bus("ex_bus fwd mem", expect_bus(alu_add, b, regs[6], 1'b1, 5'd3, regs[6],
                     pc, 1'b0, 1'b0), 1'b1, 1'b1);
        @(posedge clk);
        mem_fwd <= '0;
        wb_fwd  <= '{1'b1, 5'd5, d};    // file still holds c
        @(negedge clk);
        check_ex_bus("ex_bus fwd wb", expect_bus(alu_add, d, regs[6], 1'b1, 5'd3, regs[6], pc,
                     1'b0, 1'b0), 1'b1, 1'b1);
        @(posedge clk);
        wb_fwd  <= '0;
        regs[5] = d;                // written by wb at this edge
        @(negedge clk);
        check_ex_bus("ex_bus fwd file", expect_bus(alu_add, regs[5], regs[6], 1'b1, 5'd3,
                     regs[6], pc, 1'b0, 1'b0), 1'b1, 1'b1);
        drain();
        @(posedge clk);
        ex_fwd  <= '{1'b0, 1'b1, 5'd0, a};
        mem_fwd <= '{1'b1, 5'd0, b};
        issue(enc_rr(`ID_OP_ADD_W, 5'd3, 5'd0, 5'd6), pc);
        @(negedge clk);
        check_ex_bus("ex_bus r0 fwd", expect_bus(alu_add, '0, regs[6], 1'b1, 5'd3, regs[6],
                     pc, 1'b0, 1'b0), 1'b1, 1'b1);
        drain();
    endtask

    task automatic load_use_stall();
        logic [31:0] d;
        logic [31:0] pc;
        d  = lcg_next();
        pc = 32'h1c00_2000;
        @(posedge clk);
        ex_fwd <= '{1'b1, 1'b1, 5'd7, d};
        issue(enc_rr(`ID_OP_ADD_W, 5'd3, 5'd7, 5'd6), pc);
        @(negedge clk);
        check_bit("ex_valid stall", 1'b0, ex_valid);
        check_bit("allowin stall", 1'b0, allowin);
        @(posedge clk);
        ex_fwd <= '{1'b0, 1'b1, 5'd7, d};   // load data now on the bus
        wait_ex_valid();
        check_ex_bus("ex_bus load-use", expect_bus(alu_add, d, regs[6], 1'b1, 5'd3, regs[6],
                     pc, 1'b0, 1'b0), 1'b1, 1'b1);
        drain();
    endtask

    task automatic branch_resolve();
        logic [5:0]  ops [8] = '{`ID_OP_BEQ, `ID_OP_BNE, `ID_OP_BLT, `ID_OP_BGE,
                                 `ID_OP_BLTU, `ID_OP_BGEU, `ID_OP_B, `ID_OP_JIRL};
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] o;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] target;
        logic        taken;
        for (int k = 0; k < 8; k++) begin
            for (int it = 0; it < 2; it++) begin
                x  = lcg_next();
                y  = (it == 0) ? x : lcg_next();
                o  = lcg_next();
                pc = 32'h1c00_4000 + 32'(k * 64 + it * 16);
                write_reg(5'd8, x);
                write_reg(5'd9, y);
                case (k)
                    0: taken = (x == y);
                    1: taken = (x != y);
                    2: taken = ($signed(x) < $signed(y));
                    3: taken = !($signed(x) < $signed(y));
                    4: taken = (x < y);
                    5: taken = !(x < y);
                    default: taken = 1'b1;
                endcase
                if (k == 6) begin
                    inst   = {ops[k], o[15:0], o[25:16]};
                    target = pc + {{4{o[25]}}, o[25:0], 2'b0};
                end else begin
                    inst   = {ops[k], o[15:0], 5'd8, 5'd9};
                    target = ((k == 7) ? x : pc) + {{14{o[15]}}, o[15:0], 2'b0};
                end
                issue(inst, pc);
                if_valid <= 1'b1;   // next sequential fetch is squashed when taken
                if_bus   <= '{enc_rr(`ID_OP_ADD_W, 5'd0, 5'd0, 5'd0), pc + 32'd4};
                @(negedge clk);
                check_br("br_bus", '{taken, target});
                @(posedge clk);
                if_valid <= 1'b0;
                @(negedge clk);
                check_bit("ex_valid after branch", !taken, ex_valid);
                drain();
            end
        end
    endtask

    task automatic backpressure_hold();
        logic [31:0] pc;
        pc = 32'h1c00_3000;
        @(posedge clk);
        ex_allowin <= 1'b0;
        issue(enc_rr(`ID_OP_XOR, 5'd12, 5'd1, 5'd2), pc);
        if_valid <= 1'b1;           // must not overwrite the held instruction
        if_bus   <= '{enc_rr(`ID_OP_SUB_W, 5'd13, 5'd3, 5'd4), pc + 32'd4};
        repeat (4) begin
            @(negedge clk);
            check_bit("ex_valid held", 1'b1, ex_valid);
            check_bit("allowin held", 1'b0, allowin);
            check_ex_bus("ex_bus held", expect_bus(alu_xor, regs[1], regs[2], 1'b1, 5'd12,
                         regs[2], pc, 1'b0, 1'b0), 1'b1, 1'b1);
        end
        drain();
    endtask

    initial begin
        resetn     = 1'b0;
        if_valid   = 1'b0;
        if_bus     = '0;
        ex_allowin = 1'b1;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        regs[0]    = '0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        reset_values();
        alu_decode();
        forward_priority();
        load_use_stall();
        branch_resolve();
        backpressure_hold();
        $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/id_pkg.sv
hw/id_latch.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_unit.sv
hw/branch_unit.sv
hw/id_stage.sv
sim/tb_id_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_id_stage -o vtb_id_stage
out=$(./obj_dir/vtb_id_stage)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"
